// ==== a23_bus_settings.svh ====
//////////////////////////////////////////////////
// bus widths and sizes shared by rtl and testbench
// data width must stay 32, the ram assumes 32-bit
// beats with four byte strobes
// line words must be a power of two
//////////////////////////////////////////////////

`ifndef A23_BUS_SETTINGS_SVH
`define A23_BUS_SETTINGS_SVH

// byte address width
`define A23_ADDR_W 32

// one bus word
`define A23_DATA_W 32

// words per cache line, fetched as one wrapping burst
`define A23_LINE_WORDS 4

// depth of the test ram in words
// addresses above this alias back to the start
`define A23_RAM_WORDS 1024

`endif

// ==== a23_bus_pkg.sv ====
//////////////////////////////////////////////////
// types for the a23 axi bus interface
// widths come from the settings header
//////////////////////////////////////////////////

`include "a23_bus_settings.svh"

package a23_bus_pkg;

	// vectors that carry a meaning
	typedef logic [`A23_ADDR_W-1:0] addr_t;
	typedef logic [`A23_DATA_W-1:0] data_t;
	typedef logic [`A23_DATA_W/8-1:0] strb_t;
	// word 0 sits in the low bits, lowest address
	typedef logic [`A23_LINE_WORDS*`A23_DATA_W-1:0] line_t;
	typedef logic [$clog2(`A23_LINE_WORDS)-1:0] word_idx_t;

	// master read machine
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CORE_ADDR,
		RD_CORE_DATA,
		RD_FILL_ADDR,
		RD_FILL_DATA
	} rd_state_t;

	// master write machine, core path then write-back path
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_CACHE_ADDR,
		WR_CACHE_DATA,
		WR_CACHE_RESP
	} wr_state_t;

endpackage

// ==== a23_axi_master.sv ====
//////////////////////////////////////////////////
// core and cache requests onto one axi4 master
// requests are levels held until the stall drops
// only one request may be active at a time
// a cache read stall waits for the line fill
//////////////////////////////////////////////////

`timescale 1ns/1ps

module a23_axi_master (
	input  logic                  i_clk,
	input  logic                  i_rstn,
	// core and cache side
	input  logic                  i_select,
	input  logic                  i_write_enable,
	input  logic                  i_cache_req,
	input  a23_bus_pkg::addr_t    i_address,
	input  a23_bus_pkg::data_t    i_write_data,
	input  a23_bus_pkg::strb_t    i_byte_enable,
	output logic                  o_stall,
	output logic                  o_stall_cache,
	output a23_bus_pkg::data_t    o_read_data,
	// axi read channels
	output logic                  o_arvalid,
	output a23_bus_pkg::addr_t    o_araddr,
	output logic [7:0]            o_arlen,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	input  a23_bus_pkg::data_t    i_rdata,
	input  logic                  i_rlast,
	output logic                  o_rready,
	// axi write channels
	output logic                  o_awvalid,
	output a23_bus_pkg::addr_t    o_awaddr,
	input  logic                  i_awready,
	output logic                  o_wvalid,
	output a23_bus_pkg::data_t    o_wdata,
	output a23_bus_pkg::strb_t    o_wstrb,
	input  logic                  i_wready,
	input  logic                  i_bvalid,
	output logic                  o_bready,
	// line fill side
	output logic                  o_fill_start,
	output a23_bus_pkg::word_idx_t o_fill_idx,
	output logic                  o_fill_beat,
	output a23_bus_pkg::data_t    o_fill_data,
	output logic                  o_fill_last,
	input  logic                  i_line_done
);
	import a23_bus_pkg::*;

	// byte offset bits below the word index
	localparam int BYTE_BITS = $clog2($bits(strb_t));
	localparam int LINE_WORDS = $bits(line_t) / $bits(data_t);

	rd_state_t rd_state;
	wr_state_t wr_state;

	logic core_read_req;
	logic core_write_req;
	logic cache_read_req;
	logic cache_write_req;
	logic read_ack;
	logic write_ack;
	logic cache_write_ack;

	// decode the request levels
	assign core_read_req   = i_select && !i_write_enable;
	assign core_write_req  = i_select && i_write_enable;
	assign cache_read_req  = i_cache_req && !i_write_enable;
	assign cache_write_req = i_cache_req && i_write_enable;

	//////////////////////////////////////////////////
	// read machine
	//////////////////////////////////////////////////

	// cache fill wins over a core read
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (cache_read_req) begin
						rd_state <= RD_FILL_ADDR;
					end else if (core_read_req) begin
						rd_state <= RD_CORE_ADDR;
					end
				end
				RD_CORE_ADDR: begin
					if (i_arready) begin
						rd_state <= RD_CORE_DATA;
					end
				end
				RD_CORE_DATA: begin
					if (i_rvalid && i_rlast) begin
						rd_state <= RD_IDLE;
					end
				end
				RD_FILL_ADDR: begin
					if (i_arready) begin
						rd_state <= RD_FILL_DATA;
					end
				end
				// hold here until the line is assembled
				RD_FILL_DATA: begin
					if (i_line_done) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	assign o_arvalid = (rd_state == RD_CORE_ADDR) || (rd_state == RD_FILL_ADDR);
	assign o_araddr  = i_address;
	// four-beat wrap for a fill, single beat otherwise
	assign o_arlen   = (rd_state == RD_FILL_ADDR) ? 8'(LINE_WORDS - 1) : 8'd0;
	assign o_rready  = (rd_state == RD_CORE_DATA) || (rd_state == RD_FILL_DATA);

	// core read data passes straight through on the handshake
	assign read_ack    = (rd_state == RD_CORE_DATA) && i_rvalid && i_rlast;
	assign o_read_data = i_rdata;

	// line fill pulses
	assign o_fill_start = (rd_state == RD_FILL_ADDR) && i_arready;
	// first word of the wrap is the requested one
	assign o_fill_idx   = i_address[BYTE_BITS +: $bits(word_idx_t)];
	assign o_fill_beat  = (rd_state == RD_FILL_DATA) && i_rvalid;
	assign o_fill_data  = i_rdata;
	assign o_fill_last  = o_fill_beat && i_rlast;

	//////////////////////////////////////////////////
	// write machine
	//////////////////////////////////////////////////

	// address, data and response phases run in order
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (cache_write_req) begin
						wr_state <= WR_CACHE_ADDR;
					end else if (core_write_req) begin
						wr_state <= WR_ADDR;
					end
				end
				WR_ADDR: if (i_awready) wr_state <= WR_DATA;
				WR_DATA: if (i_wready) wr_state <= WR_RESP;
				WR_RESP: if (i_bvalid) wr_state <= WR_IDLE;
				WR_CACHE_ADDR: if (i_awready) wr_state <= WR_CACHE_DATA;
				WR_CACHE_DATA: if (i_wready) wr_state <= WR_CACHE_RESP;
				WR_CACHE_RESP: if (i_bvalid) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	assign o_awvalid = (wr_state == WR_ADDR) || (wr_state == WR_CACHE_ADDR);
	assign o_awaddr  = i_address;
	assign o_wvalid  = (wr_state == WR_DATA) || (wr_state == WR_CACHE_DATA);
	assign o_wdata   = i_write_data;
	// write-backs always carry the whole word
	assign o_wstrb   = (wr_state == WR_CACHE_DATA) ? '1 : i_byte_enable;
	assign o_bready  = (wr_state == WR_RESP) || (wr_state == WR_CACHE_RESP);

	assign write_ack       = (wr_state == WR_RESP) && i_bvalid;
	assign cache_write_ack = (wr_state == WR_CACHE_RESP) && i_bvalid;

	//////////////////////////////////////////////////
	// stalls
	//////////////////////////////////////////////////

	// low in the cycle the transaction completes
	assign o_stall = (core_read_req && !read_ack) || (core_write_req && !write_ack);

	// fill completes on line_done, the cycle after the last beat
	assign o_stall_cache =
		(cache_read_req && !((rd_state == RD_FILL_DATA) && i_line_done)) ||
		(cache_write_req && !cache_write_ack);

endmodule

// ==== a23_line_fill.sv ====
//////////////////////////////////////////////////
// gathers wrapping burst beats into a cache line
// o_line holds until the next fill writes a beat
//////////////////////////////////////////////////

`timescale 1ns/1ps

module a23_line_fill (
	input  logic                   i_clk,
	input  logic                   i_rstn,
	input  logic                   i_fill_start,
	input  a23_bus_pkg::word_idx_t i_fill_idx,
	input  logic                   i_fill_beat,
	input  a23_bus_pkg::data_t     i_fill_data,
	input  logic                   i_fill_last,
	output a23_bus_pkg::line_t     o_line,
	output logic                   o_line_done
);
	import a23_bus_pkg::*;

	localparam int DATA_W = $bits(data_t);

	// word slot for the next beat
	word_idx_t idx;

	// load the critical word index, then step with wrap
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			idx <= '0;
		end else if (i_fill_start) begin
			idx <= i_fill_idx;
		end else if (i_fill_beat) begin
			// rolls over within the line
			idx <= idx + 1'b1;
		end
	end

	// each beat lands in its own word of the line
	always_ff @(posedge i_clk) begin
		if (i_fill_beat) begin
			o_line[idx*DATA_W +: DATA_W] <= i_fill_data;
		end
	end

	// line complete one cycle after the last beat
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_line_done <= 1'b0;
		end else begin
			o_line_done <= i_fill_last;
		end
	end

endmodule

// ==== a23_axi_ram.sv ====
//////////////////////////////////////////////////
// axi4 test ram, 32-bit beats only
// reads of more than one beat wrap in a 4-word line
// writes are single beat, wlast is implied
// address taken modulo the ram depth
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "a23_bus_settings.svh"

module a23_axi_ram (
	input  logic               i_clk,
	input  logic               i_rstn,
	// read address
	input  logic               i_arvalid,
	input  a23_bus_pkg::addr_t i_araddr,
	input  logic [7:0]         i_arlen,
	output logic               o_arready,
	// read data
	output logic               o_rvalid,
	output a23_bus_pkg::data_t o_rdata,
	output logic               o_rlast,
	input  logic               i_rready,
	// write address
	input  logic               i_awvalid,
	input  a23_bus_pkg::addr_t i_awaddr,
	output logic               o_awready,
	// write data and response
	input  logic               i_wvalid,
	input  a23_bus_pkg::data_t i_wdata,
	input  a23_bus_pkg::strb_t i_wstrb,
	output logic               o_wready,
	output logic               o_bvalid,
	input  logic               i_bready
);
	import a23_bus_pkg::*;

	localparam int WORDS     = `A23_RAM_WORDS;
	localparam int IDX_W     = $clog2(WORDS);
	localparam int BYTE_BITS = $clog2($bits(strb_t));
	localparam int WRAP_BITS = $clog2(`A23_LINE_WORDS);

	typedef enum logic {R_IDLE, R_BURST} ram_rd_state_t;
	typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} ram_wr_state_t;

	data_t mem [WORDS];

	ram_rd_state_t    rd_state;
	logic [7:0]       rd_left;
	logic [IDX_W-1:0] rd_idx;
	ram_wr_state_t    wr_state;
	logic [IDX_W-1:0] wr_idx;

	// memory comes up cleared
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = '0;
		end
	end

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////

	// beats remaining after the current one
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_state <= R_IDLE;
			rd_left  <= '0;
		end else begin
			case (rd_state)
				R_IDLE: begin
					if (i_arvalid) begin
						rd_state <= R_BURST;
						rd_left  <= i_arlen;
					end
				end
				R_BURST: begin
					if (i_rready) begin
						if (rd_left == '0) begin
							rd_state <= R_IDLE;
						end
						rd_left <= rd_left - 1'b1;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// word pointer, only the low bits step so the burst wraps
	always_ff @(posedge i_clk) begin
		if (o_arready && i_arvalid) begin
			rd_idx <= i_araddr[BYTE_BITS +: IDX_W];
		end else if (o_rvalid && i_rready) begin
			rd_idx[WRAP_BITS-1:0] <= rd_idx[WRAP_BITS-1:0] + 1'b1;
		end
	end

	assign o_arready = (rd_state == R_IDLE);
	assign o_rvalid  = (rd_state == R_BURST);
	assign o_rdata   = mem[rd_idx];
	assign o_rlast   = o_rvalid && (rd_left == '0);

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_state <= W_IDLE;
		end else begin
			case (wr_state)
				W_IDLE: if (i_awvalid) wr_state <= W_DATA;
				W_DATA: if (i_wvalid) wr_state <= W_RESP;
				// response held until the master takes it
				W_RESP: if (i_bready) wr_state <= W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_awready && i_awvalid) begin
			wr_idx <= i_awaddr[BYTE_BITS +: IDX_W];
		end
	end

	// byte lanes follow the strobes
	always_ff @(posedge i_clk) begin
		if (o_wready && i_wvalid) begin
			for (int b = 0; b < $bits(strb_t); b++) begin
				if (i_wstrb[b]) begin
					mem[wr_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
			end
		end
	end

	assign o_awready = (wr_state == W_IDLE);
	assign o_wready  = (wr_state == W_DATA);
	assign o_bvalid  = (wr_state == W_RESP);

endmodule

// ==== a23_bus_top.sv ====
//////////////////////////////////////////////////
// a23 bus interface with its test ram
// one request at a time on core or cache port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module a23_bus_top (
	input  logic               i_clk,
	input  logic               i_rstn,
	input  logic               i_select,
	input  logic               i_write_enable,
	input  logic               i_cache_req,
	input  a23_bus_pkg::addr_t i_address,
	input  a23_bus_pkg::data_t i_write_data,
	input  a23_bus_pkg::strb_t i_byte_enable,
	output logic               o_stall,
	output logic               o_stall_cache,
	output a23_bus_pkg::data_t o_read_data,
	output a23_bus_pkg::line_t o_cache_line
);
	import a23_bus_pkg::*;

	// axi read channels
	logic       arvalid;
	addr_t      araddr;
	logic [7:0] arlen;
	logic       arready;
	logic       rvalid;
	data_t      rdata;
	logic       rlast;
	logic       rready;

	// axi write channels
	logic       awvalid;
	addr_t      awaddr;
	logic       awready;
	logic       wvalid;
	data_t      wdata;
	strb_t      wstrb;
	logic       wready;
	logic       bvalid;
	logic       bready;

	// master to line fill
	logic       fill_start;
	word_idx_t  fill_idx;
	logic       fill_beat;
	data_t      fill_data;
	logic       fill_last;
	logic       line_done;

	a23_axi_master a23_axi_master_i (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_select(i_select), .i_write_enable(i_write_enable),
		.i_cache_req(i_cache_req), .i_address(i_address),
		.i_write_data(i_write_data), .i_byte_enable(i_byte_enable),
		.o_stall(o_stall), .o_stall_cache(o_stall_cache), .o_read_data(o_read_data),
		.o_arvalid(arvalid), .o_araddr(araddr), .o_arlen(arlen), .i_arready(arready),
		.i_rvalid(rvalid), .i_rdata(rdata), .i_rlast(rlast), .o_rready(rready),
		.o_awvalid(awvalid), .o_awaddr(awaddr), .i_awready(awready),
		.o_wvalid(wvalid), .o_wdata(wdata), .o_wstrb(wstrb), .i_wready(wready),
		.i_bvalid(bvalid), .o_bready(bready),
		.o_fill_start(fill_start), .o_fill_idx(fill_idx), .o_fill_beat(fill_beat),
		.o_fill_data(fill_data), .o_fill_last(fill_last), .i_line_done(line_done)
	);

	a23_line_fill a23_line_fill_i (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_fill_start(fill_start), .i_fill_idx(fill_idx), .i_fill_beat(fill_beat),
		.i_fill_data(fill_data), .i_fill_last(fill_last),
		.o_line(o_cache_line), .o_line_done(line_done)
	);

	a23_axi_ram a23_axi_ram_i (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_arvalid(arvalid), .i_araddr(araddr), .i_arlen(arlen), .o_arready(arready),
		.o_rvalid(rvalid), .o_rdata(rdata), .o_rlast(rlast), .i_rready(rready),
		.i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
		.i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
		.o_bvalid(bvalid), .i_bready(bready)
	);

endmodule

// ==== a23_bus_properties.sv ====
//////////////////////////////////////////////////
// axi handshake and line fill checks
// bound to a23_axi_master, sees its port names
// one burst in flight at a time
//////////////////////////////////////////////////

`timescale 1ns/1ps

module a23_bus_properties (
	input  logic               i_clk,
	input  logic               i_rstn,
	input  logic               i_arvalid,
	input  a23_bus_pkg::addr_t i_araddr,
	input  logic [7:0]         i_arlen,
	input  logic               i_arready,
	input  logic               i_rvalid,
	input  logic               i_rready,
	input  logic               i_rlast,
	input  logic               i_awvalid,
	input  a23_bus_pkg::addr_t i_awaddr,
	input  logic               i_awready,
	input  logic               i_bvalid,
	input  logic               i_bready,
	input  logic               i_fill_last,
	input  logic               i_line_done
);
	import a23_bus_pkg::*;

	// beats seen since the last read address handshake
	logic [7:0] beat_cnt;
	logic [7:0] burst_len;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			beat_cnt  <= '0;
			burst_len <= '0;
		end else if (i_arvalid && i_arready) begin
			beat_cnt  <= '0;
			burst_len <= i_arlen;
		end else if (i_rvalid && i_rready) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// valid held with a stable address until ready
	ar_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
		else $error("arvalid dropped or araddr changed before arready");

	aw_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
		else $error("awvalid dropped or awaddr changed before awready");

	// slave side valids wait for the master
	r_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_rvalid && !i_rready |=> i_rvalid)
		else $error("rvalid dropped before rready");

	b_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("bvalid dropped before bready");

	// rlast only on the final beat, the fourth one for a fill
	rlast_pos: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_rvalid && i_rready |-> (i_rlast == (beat_cnt == burst_len)))
		else $error("rlast on the wrong beat of a burst");

	//////////////////////////////////////////////////
	// line_done exactly one cycle after fill_last
	done_after_last: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_fill_last |=> i_line_done)
		else $error("line_done missing after fill_last");

	done_only_after_last: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_line_done |-> $past(i_fill_last))
		else $error("line_done without a preceding fill_last");

endmodule

// ==== tb_a23_bus.sv ====
//////////////////////////////////////////////////
// testbench for the a23 bus interface with its ram
// one request at a time, held until its stall drops
// mirror memory starts cleared like the ram
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "a23_bus_settings.svh"

module tb_a23_bus;
	import a23_bus_pkg::*;

	localparam int N_BYTE_WR  = 8;
	localparam int N_FILL_OFS = 8;
	localparam int N_WB       = 4;
	localparam int N_RANDOM   = 300;
	// word range of the random mix, a few lines only
	localparam int RAND_WORDS = 32;
	// writes and reads, fills, write-backs with reads and one fill, random mix
	localparam int TOTAL_OPS  = 2 * N_BYTE_WR + N_FILL_OFS + 2 * N_WB + 1 + N_RANDOM;
	localparam int MAX_CYCLES = 20 * TOTAL_OPS;

	logic  clk;
	logic  rstn;
	logic  select;
	logic  write_enable;
	logic  cache_req;
	addr_t address;
	data_t write_data;
	strb_t byte_enable;
	logic  stall;
	logic  stall_cache;
	data_t read_data;
	line_t cache_line;

	data_t mirror [`A23_RAM_WORDS];
	// expected read results, one per pending read
	line_t exp_q [$];
	logic  core_rd_pend;
	logic  cache_rd_pend;
	int    cycle_cnt = 0;

	a23_bus_top a23_bus_top_i (
		.i_clk(clk), .i_rstn(rstn),
		.i_select(select), .i_write_enable(write_enable), .i_cache_req(cache_req),
		.i_address(address), .i_write_data(write_data), .i_byte_enable(byte_enable),
		.o_stall(stall), .o_stall_cache(stall_cache),
		.o_read_data(read_data), .o_cache_line(cache_line)
	);

	bind a23_axi_master a23_bus_properties a23_bus_properties_i (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_arvalid(o_arvalid), .i_araddr(o_araddr), .i_arlen(o_arlen),
		.i_arready(i_arready), .i_rvalid(i_rvalid), .i_rready(o_rready),
		.i_rlast(i_rlast), .i_awvalid(o_awvalid), .i_awaddr(o_awaddr),
		.i_awready(i_awready), .i_bvalid(i_bvalid), .i_bready(o_bready),
		.i_fill_last(o_fill_last), .i_line_done(i_line_done)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ram word for a byte address, wraps at the ram depth
	function automatic int word_index(input addr_t addr);
		return int'((addr >> 2) % `A23_RAM_WORDS);
	endfunction

	// expected read from the mirror, word in the low bits or the aligned line
	function automatic line_t expected_read(input addr_t addr, input logic whole_line);
		int    base;
		line_t line;
		base = word_index(addr) & ~(`A23_LINE_WORDS - 1);
		line = '0;
		if (whole_line) begin
			for (int w = 0; w < `A23_LINE_WORDS; w++) begin
				line[w*32 +: 32] = mirror[base + w];
			end
		end else begin
			line[31:0] = mirror[word_index(addr)];
		end
		return line;
	endfunction

	// only the enabled byte lanes change
	task automatic mirror_write(input addr_t addr, input data_t data, input strb_t strb);
		int idx;
		idx = word_index(addr);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				mirror[idx][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endtask

	task automatic check_equal(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %0h expected %0h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one request on the core or cache port, dropped the edge after completion
	task automatic run_request(input logic core, input logic wr, input addr_t addr,
			input data_t data, input strb_t strb);
		@(posedge clk);
		#1;
		select       = core;
		cache_req    = !core;
		write_enable = wr;
		address      = addr;
		write_data   = data;
		byte_enable  = strb;
		if (wr) begin
			// write-backs always store the full word
			mirror_write(addr, data, core ? strb : strb_t'('1));
		end else begin
			exp_q.push_back(expected_read(addr, !core));
			core_rd_pend  = core;
			cache_rd_pend = !core;
		end
		do begin
			@(negedge clk);
		end while (core ? stall : stall_cache);
		@(posedge clk);
		#1;
		select        = 1'b0;
		cache_req     = 1'b0;
		write_enable  = 1'b0;
		core_rd_pend  = 1'b0;
		cache_rd_pend = 1'b0;
	endtask

	// compare in the middle of the cycle where the stall is low
	always @(negedge clk) begin
		if (core_rd_pend && !stall) begin
			check_equal($sformatf("o_read_data at %h", address),
				line_t'(read_data), exp_q.pop_front());
		end
		if (cache_rd_pend && !stall_cache) begin
			check_equal($sformatf("o_cache_line at %h", address),
				cache_line, exp_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout, requests still stalled after %0d cycles", cycle_cnt);
			$display("TESTBENCH FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	initial begin
		logic [1:0] kind;
		addr_t      addr;
		void'($urandom(32'h3734));
		rstn          = 1'b0;
		select        = 1'b0;
		write_enable  = 1'b0;
		cache_req     = 1'b0;
		address       = '0;
		write_data    = '0;
		byte_enable   = '0;
		core_rd_pend  = 1'b0;
		cache_rd_pend = 1'b0;
		for (int i = 0; i < `A23_RAM_WORDS; i++) begin
			mirror[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		rstn = 1'b1;

		// nothing requested, both stalls idle
		@(negedge clk);
		check_equal("o_stall", line_t'(stall), '0);
		check_equal("o_stall_cache", line_t'(stall_cache), '0);

		// core writes with mixed strobes, then read back
		for (int w = 0; w < N_BYTE_WR; w++) begin
			run_request(1'b1, 1'b1, addr_t'(w * 4), $urandom, strb_t'(w + 1));
		end
		for (int w = 0; w < N_BYTE_WR; w++) begin
			run_request(1'b1, 1'b0, addr_t'(w * 4), '0, '0);
		end

		// fills starting at every word offset of two lines
		for (int i = 0; i < N_FILL_OFS; i++) begin
			run_request(1'b0, 1'b0, addr_t'(i * 4), '0, '0);
		end

		// write-backs of one line, read by the core and as a fill
		for (int w = 0; w < N_WB; w++) begin
			run_request(1'b0, 1'b1, addr_t'('h40 + w * 4), $urandom, '0);
		end
		for (int w = 0; w < N_WB; w++) begin
			run_request(1'b1, 1'b0, addr_t'('h40 + w * 4), '0, '0);
		end
		run_request(1'b0, 1'b0, addr_t'('h44), '0, '0);

		// random mix, bit 1 picks the core port, bit 0 a write
		for (int n = 0; n < N_RANDOM; n++) begin
			kind = 2'($urandom % 4);
			addr = addr_t'(($urandom % RAND_WORDS) * 4);
			run_request(kind[1], kind[0], addr, $urandom, strb_t'($urandom));
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
a23_bus_pkg.sv
a23_axi_master.sv
a23_line_fill.sv
a23_axi_ram.sv
a23_bus_top.sv
a23_bus_properties.sv
tb_a23_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the a23 bus testbench with verilator
# the run fails if the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="TESTBENCH FAILED"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_a23_bus
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

./obj_dir/Vtb_a23_bus > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

echo "simulation passed"
exit 0
